//--- rtl/daq_tx_pkg.sv
`default_nettype none

package daq_tx_pkg;

	typedef logic [15:0] line_word_t;   // Low octet goes out first
	typedef logic [1:0]  charisk_t;     // One K flag per octet
	typedef logic [31:0] crc_t;
	typedef logic [9:0]  pkt_len_t;     // Data words per packet

	//////////////////////////////
	// 8b/10b octets
	//////////////////////////////

	localparam logic [7:0] D5_6     = 8'hC5;
	localparam logic [7:0] D16_2    = 8'h50;
	localparam logic [7:0] K28_5    = 8'hBC;
	localparam logic [7:0] K23_7    = 8'hF7;   // /R/ carrier extend
	localparam logic [7:0] K27_7    = 8'hFB;   // /S/ start of packet
	localparam logic [7:0] K29_7    = 8'hFD;   // /T/ end of packet
	localparam logic [7:0] PRMBL    = 8'h55;
	localparam logic [7:0] SOF_BYTE = 8'hD5;

	// Ordered-set words, high octet on the left
	localparam line_word_t IDLE2       = {D16_2, K28_5};
	localparam line_word_t SOP_PRE     = {PRMBL, K27_7};
	localparam line_word_t PREAMBLE    = {PRMBL, PRMBL};
	localparam line_word_t SOF_PRE     = {SOF_BYTE, PRMBL};
	localparam line_word_t EOP_WORD    = {K23_7, K29_7};
	localparam line_word_t CARRIER_EXT = {K23_7, K23_7};

	// K tags
	localparam charisk_t K_TAG_NONE = 2'b00;   // Preamble, SOF, data, CRC
	localparam charisk_t K_TAG_LOW  = 2'b01;   // Idle and SOP
	localparam charisk_t K_TAG_BOTH = 2'b11;   // EOP and carrier extend

	localparam pkt_len_t DEFAULT_PKT_LEN = 10'd800;

	typedef enum logic [2:0] {
		OS_IDLE,
		OS_SOP,
		OS_PREAMBLE,
		OS_SOF,
		OS_EOP,
		OS_CAR_EXT
	} os_sel_t;

	// Source of the next line word
	typedef enum logic [1:0] {
		WS_ROM,
		WS_DATA,
		WS_CRC_LO,
		WS_CRC_HI
	} word_sel_t;

endpackage

`default_nettype wire

//--- rtl/daq_reset_sync.sv
`timescale 1ns/100ps
`default_nettype none

module daq_reset_sync #(
	parameter int RST_STAGES = 4
)
(
	input  logic usr_clk_wordwise,
	input  logic arst,
	input  logic pll_lock_i,
	output logic line_rst_o
);

	logic [RST_STAGES-1:0] rst_sr;

	//////////////////////////////
	// Reset release chain
	//////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			rst_sr <= '1;
		else if (pll_lock_i)
			rst_sr <= rst_sr << 1;   // Chain only advances while locked
	end

	assign line_rst_o = rst_sr[RST_STAGES-1];

	// Once released, the line stays out of reset until the next arst
	assert property (@(posedge usr_clk_wordwise) disable iff (arst)
		!line_rst_o |=> !line_rst_o);

endmodule

`default_nettype wire

//--- rtl/frame_proc_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module frame_proc_fsm #(
	parameter int IPG_WORDS = 6
)
(
	input  logic                  usr_clk_wordwise,
	input  logic                  arst,
	input  logic                  line_rst_i,
	input  logic                  txd_valid_i,
	output logic                  txd_ready_o,
	output daq_tx_pkg::os_sel_t   os_sel_o,
	output daq_tx_pkg::word_sel_t word_sel_o,
	output logic                  crc_init_o,
	output logic                  crc_calc_o,
	output daq_tx_pkg::pkt_len_t  last_pkt_len_o
);

	import daq_tx_pkg::*;

	localparam int CNT_W = (IPG_WORDS > 2) ? $clog2(IPG_WORDS) : 1;

	typedef enum logic [3:0] {
		S_IDLE,
		S_SOP,
		S_PREAMBLE,
		S_SOF,
		S_DATA,
		S_CRC_HI,
		S_EOP,
		S_CAR_EXT,
		S_GAP
	} state_t;

	state_t           state;
	state_t           state_nxt;
	logic [CNT_W-1:0] cnt;       // Preamble and gap length
	pkt_len_t         pkt_cnt;
	logic             xfer;
	logic             pkt_end;

	assign txd_ready_o = (state == S_DATA);
	assign xfer        = txd_ready_o & txd_valid_i;
	assign pkt_end     = txd_ready_o & ~txd_valid_i;   // Valid dropped under ready
	assign crc_calc_o  = xfer;
	assign crc_init_o  = (state == S_SOP);

	always_comb
	begin
		state_nxt = state;
		case (state)
			S_IDLE:
				if (txd_valid_i)
					state_nxt = S_SOP;
			S_SOP:      state_nxt = S_PREAMBLE;
			S_PREAMBLE:
				if (cnt == CNT_W'(1))
					state_nxt = S_SOF;
			S_SOF:      state_nxt = S_DATA;
			S_DATA:
				if (pkt_end)
					state_nxt = S_CRC_HI;
			S_CRC_HI:   state_nxt = S_EOP;
			S_EOP:      state_nxt = S_CAR_EXT;
			S_CAR_EXT:  state_nxt = S_GAP;
			S_GAP:
				if (cnt == CNT_W'(IPG_WORDS - 1))
					state_nxt = txd_valid_i ? S_SOP : S_IDLE;   // Back to back
			default:    state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			state <= S_IDLE;
			cnt   <= '0;
		end
		else if (line_rst_i)
		begin
			state <= S_IDLE;
			cnt   <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (state_nxt != state)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

	// Word selection for this cycle
	always_comb
	begin
		os_sel_o   = OS_IDLE;
		word_sel_o = WS_ROM;
		case (state)
			S_SOP:      os_sel_o = OS_SOP;
			S_PREAMBLE: os_sel_o = OS_PREAMBLE;
			S_SOF:      os_sel_o = OS_SOF;
			S_DATA:     word_sel_o = pkt_end ? WS_CRC_LO : WS_DATA;   // End cycle sends CRC low
			S_CRC_HI:   word_sel_o = WS_CRC_HI;
			S_EOP:      os_sel_o = OS_EOP;
			S_CAR_EXT:  os_sel_o = OS_CAR_EXT;
			default:    os_sel_o = OS_IDLE;
		endcase
	end

	//////////////////////////////
	// Packet length
	//////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			pkt_cnt        <= '0;
			last_pkt_len_o <= DEFAULT_PKT_LEN;
		end
		else
		begin
			if (crc_init_o)
				pkt_cnt <= '0;
			else if (xfer)
				pkt_cnt <= pkt_cnt + 1'b1;
			if (pkt_end)
				last_pkt_len_o <= pkt_cnt;
		end
	end

	// Ready is entered only from start of frame and held only in data
	assert property (@(posedge usr_clk_wordwise) disable iff (arst)
		txd_ready_o |-> $past(state) inside {S_SOF, S_DATA});

endmodule

`default_nettype wire

//--- rtl/ordered_set_rom.sv
`timescale 1ns/100ps
`default_nettype none

module ordered_set_rom
(
	input  logic                   usr_clk_wordwise,
	input  daq_tx_pkg::os_sel_t    os_sel_i,
	output daq_tx_pkg::line_word_t os_word_o,
	output daq_tx_pkg::charisk_t   os_charisk_o
);

	import daq_tx_pkg::*;

	//////////////////////////////
	// Word ROM
	//////////////////////////////

	always_ff @(posedge usr_clk_wordwise)
	begin
		case (os_sel_i)
			OS_IDLE:     os_word_o <= IDLE2;
			OS_SOP:      os_word_o <= SOP_PRE;
			OS_PREAMBLE: os_word_o <= PREAMBLE;
			OS_SOF:      os_word_o <= SOF_PRE;
			OS_EOP:      os_word_o <= EOP_WORD;
			OS_CAR_EXT:  os_word_o <= CARRIER_EXT;
			default:     os_word_o <= IDLE2;
		endcase
	end

	// Matching K tags
	always_ff @(posedge usr_clk_wordwise)
	begin
		case (os_sel_i)
			OS_IDLE:     os_charisk_o <= K_TAG_LOW;
			OS_SOP:      os_charisk_o <= K_TAG_LOW;    // K27_7 in low octet
			OS_PREAMBLE: os_charisk_o <= K_TAG_NONE;
			OS_SOF:      os_charisk_o <= K_TAG_NONE;
			OS_EOP:      os_charisk_o <= K_TAG_BOTH;
			OS_CAR_EXT:  os_charisk_o <= K_TAG_BOTH;
			default:     os_charisk_o <= K_TAG_LOW;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/crc32_gen.sv
`timescale 1ns/100ps
`default_nettype none

module crc32_gen
(
	input  logic                   usr_clk_wordwise,
	input  logic                   arst,
	input  logic                   line_rst_i,
	input  logic                   crc_init_i,
	input  logic                   crc_calc_i,
	input  daq_tx_pkg::line_word_t data_i,
	output daq_tx_pkg::crc_t       crc_o
);

	import daq_tx_pkg::*;

	localparam crc_t CRC_POLY_REFL = 32'hEDB88320;   // 04C11DB7 bit reversed

	crc_t crc_reg;

	// One octet, LSB first
	function automatic crc_t crc_octet(input crc_t crc_in, input logic [7:0] octet);
		crc_t c;
		int   i;
		c = crc_in ^ {24'h000000, octet};
		for (i = 0; i < 8; i++)
		begin
			if (c[0])
				c = (c >> 1) ^ CRC_POLY_REFL;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			crc_reg <= '1;
		else if (line_rst_i || crc_init_i)
			crc_reg <= '1;
		else if (crc_calc_i)
			crc_reg <= crc_octet(crc_octet(crc_reg, data_i[7:0]), data_i[15:8]);
	end

	assign crc_o = ~crc_reg;   // FCS is the complement

	// Clear and update come from different FSM states
	assert property (@(posedge usr_clk_wordwise) disable iff (arst)
		!(crc_init_i && crc_calc_i));

endmodule

`default_nettype wire

//--- rtl/frame_word_mux.sv
`timescale 1ns/100ps
`default_nettype none

module frame_word_mux
(
	input  logic                   usr_clk_wordwise,
	input  logic                   arst,
	input  logic                   line_rst_i,
	input  daq_tx_pkg::word_sel_t  word_sel_i,
	input  daq_tx_pkg::line_word_t data_i,
	input  daq_tx_pkg::crc_t       crc_i,
	input  daq_tx_pkg::line_word_t os_word_i,
	input  daq_tx_pkg::charisk_t   os_charisk_i,
	output daq_tx_pkg::line_word_t line_word_o,
	output daq_tx_pkg::charisk_t   line_charisk_o
);

	import daq_tx_pkg::*;

	word_sel_t  word_sel_d;
	line_word_t data_d;
	line_word_t word_nxt;
	charisk_t   charisk_nxt;

	//////////////////////////////
	// Align with the ROM stage
	//////////////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			word_sel_d <= WS_ROM;
		else
			word_sel_d <= word_sel_i;
	end

	always_ff @(posedge usr_clk_wordwise)
	begin
		data_d <= data_i;
	end

	always_comb
	begin
		case (word_sel_d)
			WS_DATA:
			begin
				word_nxt    = data_d;
				charisk_nxt = K_TAG_NONE;
			end
			WS_CRC_LO:
			begin
				word_nxt    = crc_i[15:0];   // Low half leaves first
				charisk_nxt = K_TAG_NONE;
			end
			WS_CRC_HI:
			begin
				word_nxt    = crc_i[31:16];
				charisk_nxt = K_TAG_NONE;
			end
			default:
			begin
				word_nxt    = os_word_i;
				charisk_nxt = os_charisk_i;
			end
		endcase
	end

	// Output register
	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst || line_rst_i)
		begin
			line_word_o    <= IDLE2;       // Idles until the line is up
			line_charisk_o <= K_TAG_LOW;
		end
		else
		begin
			line_word_o    <= word_nxt;
			line_charisk_o <= charisk_nxt;
		end
	end

endmodule

`default_nettype wire

//--- rtl/daq_frame_tx.sv
`timescale 1ns/100ps
`default_nettype none

module daq_frame_tx #(
	parameter int IPG_WORDS  = 6,
	parameter int RST_STAGES = 4
)
(
	input  logic                   usr_clk_wordwise,
	input  logic                   arst,
	input  logic                   pll_lock_i,
	input  daq_tx_pkg::line_word_t txd_i,
	input  logic                   txd_valid_i,
	output logic                   txd_ready_o,
	output daq_tx_pkg::line_word_t line_word_o,
	output daq_tx_pkg::charisk_t   line_charisk_o,
	output daq_tx_pkg::pkt_len_t   last_pkt_len_o
);

	import daq_tx_pkg::*;

	logic       line_rst;
	os_sel_t    os_sel;
	word_sel_t  word_sel;
	logic       crc_init;
	logic       crc_calc;
	crc_t       crc;
	line_word_t os_word;
	charisk_t   os_charisk;

	daq_reset_sync #(
		.RST_STAGES (RST_STAGES)
	) daq_reset_sync_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.pll_lock_i       (pll_lock_i),
		.line_rst_o       (line_rst)
	);

	frame_proc_fsm #(
		.IPG_WORDS (IPG_WORDS)
	) frame_proc_fsm_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.line_rst_i       (line_rst),
		.txd_valid_i      (txd_valid_i),
		.txd_ready_o      (txd_ready_o),
		.os_sel_o         (os_sel),
		.word_sel_o       (word_sel),
		.crc_init_o       (crc_init),
		.crc_calc_o       (crc_calc),
		.last_pkt_len_o   (last_pkt_len_o)
	);

	ordered_set_rom ordered_set_rom_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.os_sel_i         (os_sel),
		.os_word_o        (os_word),
		.os_charisk_o     (os_charisk)
	);

	crc32_gen crc32_gen_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.line_rst_i       (line_rst),
		.crc_init_i       (crc_init),
		.crc_calc_i       (crc_calc),
		.data_i           (txd_i),
		.crc_o            (crc)
	);

	frame_word_mux frame_word_mux_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.line_rst_i       (line_rst),
		.word_sel_i       (word_sel),
		.data_i           (txd_i),
		.crc_i            (crc),
		.os_word_i        (os_word),
		.os_charisk_i     (os_charisk),
		.line_word_o      (line_word_o),
		.line_charisk_o   (line_charisk_o)
	);

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS  = 100,
	parameter int RST_CYCLES = 8
)
(
	output logic clk_o,
	output logic arst_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Released just after the last reset edge
	initial
	begin
		arst_o = 1'b1;
		repeat (RST_CYCLES)
			@(posedge clk_o);
		#1 arst_o = 1'b0;
	end

endmodule

`default_nettype wire

//--- verification/daq_frame_tx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module daq_frame_tx_tb;

	localparam int IPG_WORDS  = 6;
	localparam int RST_STAGES = 4;
	localparam int SEED       = 28730;
	localparam int WAIT_LIMIT = 400;   // Cycles per wait loop
	localparam int MAX_FRAME  = 200;

	// Line words, high octet first
	localparam logic [15:0] IDLE_WORD = 16'h50BC;
	localparam logic [15:0] SOP_WORD  = 16'h55FB;
	localparam logic [15:0] PRE_WORD  = 16'h5555;
	localparam logic [15:0] SOF_WORD  = 16'hD555;
	localparam logic [15:0] EOP_WORD  = 16'hF7FD;
	localparam logic [15:0] CEXT_WORD = 16'hF7F7;

	logic        usr_clk_wordwise;
	logic        arst;
	logic        pll_lock_i;
	logic [15:0] txd_i;
	logic        txd_valid_i;
	logic        txd_ready_o;
	logic [15:0] line_word_o;
	logic [1:0]  line_charisk_o;
	logic [9:0]  last_pkt_len_o;

	logic [15:0] exp_data_q[$];    // Words taken by the DUT
	logic [17:0] exp_frame_q[$];   // {tags, word}
	logic [17:0] rx_q[$];
	logic [15:0] held_q[$];
	logic [15:0] rx_first_q[$];
	int          sent_len_q[$];
	int          exp_gap_q[$];
	int          rx_len_q[$];
	int          rx_gap_q[$];
	int          ready_run_q[$];
	int          err_cnt = 0;
	int          check_cnt = 0;
	int          frames_checked = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	tb_clk_gen #(
		.PERIOD_NS  (100),
		.RST_CYCLES (8)
	) tb_clk_gen_i (
		.clk_o  (usr_clk_wordwise),
		.arst_o (arst)
	);

	daq_frame_tx #(
		.IPG_WORDS  (IPG_WORDS),
		.RST_STAGES (RST_STAGES)
	) daq_frame_tx_i (
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.pll_lock_i       (pll_lock_i),
		.txd_i            (txd_i),
		.txd_valid_i      (txd_valid_i),
		.txd_ready_o      (txd_ready_o),
		.line_word_o      (line_word_o),
		.line_charisk_o   (line_charisk_o),
		.last_pkt_len_o   (last_pkt_len_o)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Reflected CRC-32, one bit per step, LSB first
	function automatic logic [31:0] fcs_octet(input logic [31:0] crc, input logic [7:0] octet);
		logic [31:0] c;
		logic        fb;
		int          b;
		c = crc;
		for (b = 0; b < 8; b++)
		begin
			fb = c[0] ^ octet[b];
			c  = {1'b0, c[31:1]};
			if (fb)
				c = c ^ 32'hEDB88320;
		end
		return c;
	endfunction

	function automatic void build_expected_frame(input int n);
		logic [31:0] crc;
		logic [15:0] w;
		int          i;
		exp_frame_q.delete();
		crc = 32'hFFFF_FFFF;
		exp_frame_q.push_back({2'b01, SOP_WORD});
		exp_frame_q.push_back({2'b00, PRE_WORD});
		exp_frame_q.push_back({2'b00, PRE_WORD});
		exp_frame_q.push_back({2'b00, SOF_WORD});
		for (i = 0; i < n; i++)
		begin
			w   = exp_data_q.pop_front();
			crc = fcs_octet(fcs_octet(crc, w[7:0]), w[15:8]);   // Low octet first
			exp_frame_q.push_back({2'b00, w});
		end
		crc = ~crc;
		exp_frame_q.push_back({2'b00, crc[15:0]});
		exp_frame_q.push_back({2'b00, crc[31:16]});
		exp_frame_q.push_back({2'b11, EOP_WORD});
		exp_frame_q.push_back({2'b11, CEXT_WORD});
	endfunction

	// Idles seen when valid rises raise_delay cycles into the CRC high word
	function automatic int expected_gap(input int raise_delay);
		int late;
		late = raise_delay - (IPG_WORDS + 2);
		return (late > 0) ? IPG_WORDS + late : IPG_WORDS;
	endfunction

	function automatic logic [15:0] random_word();
		logic [31:0] r;
		r = $urandom();
		return r[15:0];
	endfunction

	//////////////////////////////
	// Checks and report
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		err_cnt++;
		$display("FAILED: %s", what);
	endtask

	task automatic abort_run(input string what);
		$display("FAILED: %s", what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic report_test(input int num, input string name, input int errs);
		tests_run++;
		if (errs == 0)
			$display("test %0d %s: passed", num, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", num, name, errs);
		end
	endtask

	task automatic next_cycle();
		@(posedge usr_clk_wordwise);
		#1;
	endtask

	task automatic wait_frames(input int target);
		int waited;
		waited = 0;
		while (frames_checked < target && waited < WAIT_LIMIT)
		begin
			waited++;
			@(negedge usr_clk_wordwise);
		end
		if (frames_checked < target)
			abort_run($sformatf("frame %0d never completed on the line", target));
		next_cycle();
	endtask

	// Offers len words, one per cycle once ready is high
	task automatic send_packet(input int len, input int delay, input bit chained);
		int sent;
		int waited;
		sent_len_q.push_back(len);
		exp_gap_q.push_back(chained ? expected_gap(delay) : -1);
		repeat (delay)
			next_cycle();
		if (!txd_valid_i)
		begin
			txd_i       = random_word();
			txd_valid_i = 1'b1;
		end
		held_q.push_back(txd_i);   // An earlier offer keeps its word
		sent = 0;
		while (sent < len)
		begin
			waited = 0;
			@(negedge usr_clk_wordwise);
			while (!txd_ready_o && waited < WAIT_LIMIT)
			begin
				waited++;
				@(negedge usr_clk_wordwise);
			end
			if (!txd_ready_o)
				abort_run("a source word was never taken");
			exp_data_q.push_back(txd_i);
			sent++;
			next_cycle();
			if (sent < len)
				txd_i = random_word();
			else
				txd_valid_i = 1'b0;
		end
		next_cycle();   // End cycle, valid low under ready
	endtask

	//////////////////////////////
	// Monitors
	//////////////////////////////

	initial
	begin : line_monitor
		bit in_frame;
		bit have_prev;
		int frame_len;
		int idle_cnt;
		in_frame  = 1'b0;
		have_prev = 1'b0;
		frame_len = 0;
		idle_cnt  = 0;
		forever
		begin
			@(negedge usr_clk_wordwise);
			if (!arst)
			begin
				if (in_frame)
				begin
					rx_q.push_back({line_charisk_o, line_word_o});
					frame_len++;
					if ((line_word_o == CEXT_WORD && line_charisk_o == 2'b11) ||
						frame_len >= MAX_FRAME)
					begin
						rx_len_q.push_back(frame_len);
						in_frame  = 1'b0;
						have_prev = 1'b1;
						idle_cnt  = 0;
					end
				end
				else if (line_word_o == SOP_WORD && line_charisk_o == 2'b01)
				begin
					rx_gap_q.push_back(have_prev ? idle_cnt : -1);
					rx_q.push_back({line_charisk_o, line_word_o});
					frame_len = 1;
					in_frame  = 1'b1;
				end
				else if (line_word_o == IDLE_WORD && line_charisk_o == 2'b01)
					idle_cnt++;
				else
					report_failure($sformatf("line word %h with tags %b outside a frame",
						line_word_o, line_charisk_o));
			end
		end
	end

	// Lengths of the ready pulses, one per packet
	initial
	begin : ready_monitor
		int run;
		run = 0;
		forever
		begin
			@(negedge usr_clk_wordwise);
			if (!arst && txd_ready_o)
				run++;
			else if (run > 0)
			begin
				ready_run_q.push_back(run);
				run = 0;
			end
		end
	end

	initial
	begin : compare_frames
		int          n;
		int          rx_len;
		int          gap;
		int          exp_gap;
		int          run;
		int          i;
		logic [17:0] got;
		forever
		begin
			@(negedge usr_clk_wordwise);
			if (rx_len_q.size() > 0 && sent_len_q.size() > 0)
			begin
				n       = sent_len_q.pop_front();
				exp_gap = exp_gap_q.pop_front();
				rx_len  = rx_len_q.pop_front();
				gap     = rx_gap_q.pop_front();
				run     = (ready_run_q.size() > 0) ? ready_run_q.pop_front() : 0;
				build_expected_frame(n);
				check_value("frame length", 32'(rx_len), 32'(exp_frame_q.size()));
				for (i = 0; i < rx_len; i++)
				begin
					got = rx_q.pop_front();
					if (i == 4)
						rx_first_q.push_back(got[15:0]);
					if (i < exp_frame_q.size())
					begin
						check_value($sformatf("line_word_o[%0d]", i), 32'(got[15:0]),
							32'(exp_frame_q[i][15:0]));
						check_value($sformatf("line_charisk_o[%0d]", i), 32'(got[17:16]),
							32'(exp_frame_q[i][17:16]));
					end
				end
				check_value("last_pkt_len_o", 32'(last_pkt_len_o), 32'(n));
				check_value("txd_ready_o cycles", 32'(run), 32'(n + 1));   // Data plus end cycle
				if (gap >= 0 && exp_gap >= 0)
					check_value("gap idles", 32'(gap), 32'(exp_gap));
				else if (gap >= 0 && gap < IPG_WORDS)
					report_failure($sformatf("gap of only %0d idles before a packet", gap));
				frames_checked++;
			end
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin : main_flow
		int          seed;
		int          errs_before;
		int          len;
		int          i;
		int          waited;
		int          base;
		logic [31:0] crc;
		seed        = $urandom(SEED);
		pll_lock_i  = 1'b0;
		txd_i       = '0;
		txd_valid_i = 1'b0;

		// Unlocked PLL keeps the line idle, even with a word on offer
		errs_before = err_cnt;
		waited      = 0;
		while (arst && waited < WAIT_LIMIT)
		begin
			waited++;
			@(negedge usr_clk_wordwise);
		end
		if (arst)
			abort_run("arst was never released");
		next_cycle();
		txd_i       = random_word();
		txd_valid_i = 1'b1;
		repeat (20)
		begin
			@(negedge usr_clk_wordwise);
			check_value("line_word_o", 32'(line_word_o), 32'(IDLE_WORD));
			check_value("line_charisk_o", 32'(line_charisk_o), 32'h1);
			check_value("txd_ready_o", 32'(txd_ready_o), 32'h0);
			check_value("last_pkt_len_o", 32'(last_pkt_len_o), 32'd800);
		end
		next_cycle();
		pll_lock_i = 1'b1;
		send_packet($urandom_range(1, 40), 0, 1'b0);   // Takes the word already offered
		wait_frames(1);
		report_test(1, "idle line before lock", err_cnt - errs_before);

		errs_before = err_cnt;
		send_packet($urandom_range(1, 40), 0, 1'b0);
		wait_frames(2);
		report_test(2, "single packet framing and data", err_cnt - errs_before);

		errs_before = err_cnt;
		crc = 32'hFFFF_FFFF;
		for (i = 0; i < 9; i++)
			crc = fcs_octet(crc, 8'h31 + 8'(i));   // ASCII 123456789
		check_value("reference FCS", ~crc, 32'hCBF43926);
		send_packet($urandom_range(1, 40), 0, 1'b0);
		wait_frames(3);
		report_test(3, "CRC, EOP and carrier extend", err_cnt - errs_before);

		errs_before = err_cnt;
		len = 1;
		send_packet(len, 0, 1'b0);
		wait_frames(4);
		check_value("last_pkt_len_o", 32'(last_pkt_len_o), 32'(len));
		len = $urandom_range(2, 60);
		send_packet(len, 0, 1'b0);
		wait_frames(5);
		check_value("last_pkt_len_o", 32'(last_pkt_len_o), 32'(len));
		report_test(4, "packet length capture", err_cnt - errs_before);

		errs_before = err_cnt;
		base = frames_checked;
		send_packet($urandom_range(1, 30), 0, 1'b0);
		send_packet($urandom_range(1, 30), 0, 1'b1);
		send_packet($urandom_range(1, 30), 0, 1'b1);
		wait_frames(base + 3);
		report_test(5, "back to back packets", err_cnt - errs_before);

		// Valid rises somewhere in the gap and must be held
		errs_before = err_cnt;
		held_q.delete();
		rx_first_q.delete();
		base = frames_checked;
		send_packet($urandom_range(1, 30), 0, 1'b0);
		for (i = 0; i < 3; i++)
			send_packet($urandom_range(1, 30), $urandom_range(0, IPG_WORDS + 4), 1'b1);
		wait_frames(base + 4);
		check_value("held word count", 32'(rx_first_q.size()), 32'(held_q.size()));
		for (i = 0; i < held_q.size() && i < rx_first_q.size(); i++)
			check_value($sformatf("first data word %0d", i), 32'(rx_first_q[i]),
				32'(held_q[i]));
		report_test(6, "valid held through the gap", err_cnt - errs_before);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
rtl/daq_tx_pkg.sv
rtl/daq_reset_sync.sv
rtl/frame_proc_fsm.sv
rtl/ordered_set_rom.sv
rtl/crc32_gen.sv
rtl/frame_word_mux.sv
rtl/daq_frame_tx.sv
verification/tb_clk_gen.sv
verification/daq_frame_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the daq_frame_tx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f src.f --top-module daq_frame_tx_tb \
	--Mdir obj_dir -o daq_frame_tx_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

sim_out=$(./obj_dir/daq_frame_tx_sim)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^TEST RESULT: PASS$'; then
	exit 0
else
	exit 1
fi
